/* include/simple_system_cfg.svh */
`ifndef SIMPLE_SYSTEM_CFG_SVH
`define SIMPLE_SYSTEM_CFG_SVH

// Bus data and address width
`define SS_DATA_W 32

// Number of devices behind the bus
`define SS_NUM_DEV 3

// Bit positions in the device select
`define SS_SEL_RAM 0
`define SS_SEL_SIM 1
`define SS_SEL_TMR 2

// RAM window, 4 kB
`define SS_RAM_BASE 32'h0010_0000
`define SS_RAM_MASK 32'hFFFF_F000

// Simulator control window, 1 kB
`define SS_SIMCTRL_BASE 32'h0002_0000
`define SS_SIMCTRL_MASK 32'hFFFF_FC00

// Machine timer window, 1 kB
`define SS_TIMER_BASE 32'h0003_0000
`define SS_TIMER_MASK 32'hFFFF_FC00

// RAM depth in words
`define SS_RAM_WORDS 1024

`endif

/* hdl/simple_system_pkg.sv */
package simple_system_pkg;

`include "simple_system_cfg.svh"

  // Byte address on the bus
  typedef logic [`SS_DATA_W-1:0] addr_t;

  // One bus data word
  typedef logic [`SS_DATA_W-1:0] data_t;

  // One enable per byte lane
  typedef logic [`SS_DATA_W/8-1:0] be_t;

  // One-hot device select, bit positions from the SS_SEL_* macros
  // zero means the address hit no window
  typedef logic [`SS_NUM_DEV-1:0] dev_sel_t;

endpackage

/* hdl/bus.sv */
`timescale 1ns/1ns
`include "simple_system_cfg.svh"

module bus (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     host_req_i,
  input  simple_system_pkg::addr_t host_addr_i,
  input  logic                     host_we_i,
  input  simple_system_pkg::be_t   host_be_i,
  input  simple_system_pkg::data_t host_wdata_i,
  output logic                     host_gnt_o,
  output logic                     host_rvalid_o,
  output simple_system_pkg::data_t host_rdata_o,
  output logic                     host_err_o,

  output logic                     ram_req_o,
  output simple_system_pkg::addr_t ram_addr_o,
  output logic                     ram_we_o,
  output simple_system_pkg::be_t   ram_be_o,
  output simple_system_pkg::data_t ram_wdata_o,
  input  logic                     ram_rvalid_i,
  input  simple_system_pkg::data_t ram_rdata_i,
  input  logic                     ram_err_i,

  output logic                     sim_req_o,
  output simple_system_pkg::addr_t sim_addr_o,
  output logic                     sim_we_o,
  output simple_system_pkg::be_t   sim_be_o,
  output simple_system_pkg::data_t sim_wdata_o,
  input  logic                     sim_rvalid_i,
  input  simple_system_pkg::data_t sim_rdata_i,
  input  logic                     sim_err_i,

  output logic                     tmr_req_o,
  output simple_system_pkg::addr_t tmr_addr_o,
  output logic                     tmr_we_o,
  output simple_system_pkg::be_t   tmr_be_o,
  output simple_system_pkg::data_t tmr_wdata_o,
  input  logic                     tmr_rvalid_i,
  input  simple_system_pkg::data_t tmr_rdata_i,
  input  logic                     tmr_err_i
);

  import simple_system_pkg::*;

  dev_sel_t sel;
  dev_sel_t sel_q;
  logic     unmapped_q;

  // Window hits under each device mask
  assign sel[`SS_SEL_RAM] = (host_addr_i & `SS_RAM_MASK) == `SS_RAM_BASE;
  assign sel[`SS_SEL_SIM] = (host_addr_i & `SS_SIMCTRL_MASK) == `SS_SIMCTRL_BASE;
  assign sel[`SS_SEL_TMR] = (host_addr_i & `SS_TIMER_MASK) == `SS_TIMER_BASE;

  // No back-pressure, every request is granted
  assign host_gnt_o = host_req_i;

  // Request goes only to the device that was hit
  assign ram_req_o = host_req_i & sel[`SS_SEL_RAM];
  assign sim_req_o = host_req_i & sel[`SS_SEL_SIM];
  assign tmr_req_o = host_req_i & sel[`SS_SEL_TMR];

  // Payload is broadcast, the request strobe qualifies it
  assign ram_addr_o  = host_addr_i;
  assign ram_we_o    = host_we_i;
  assign ram_be_o    = host_be_i;
  assign ram_wdata_o = host_wdata_i;
  assign sim_addr_o  = host_addr_i;
  assign sim_we_o    = host_we_i;
  assign sim_be_o    = host_be_i;
  assign sim_wdata_o = host_wdata_i;
  assign tmr_addr_o  = host_addr_i;
  assign tmr_we_o    = host_we_i;
  assign tmr_be_o    = host_be_i;
  assign tmr_wdata_o = host_wdata_i;

  // Remember who owes the response next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q      <= '0;
      unmapped_q <= 1'b0;
    end else begin
      sel_q      <= host_req_i ? sel : '0;
      unmapped_q <= host_req_i & (sel == '0);
    end
  end

  // Response mux, unmapped requests answer with err and zero data
  assign host_rvalid_o = unmapped_q
                       | (sel_q[`SS_SEL_RAM] & ram_rvalid_i)
                       | (sel_q[`SS_SEL_SIM] & sim_rvalid_i)
                       | (sel_q[`SS_SEL_TMR] & tmr_rvalid_i);
  assign host_err_o    = unmapped_q
                       | (sel_q[`SS_SEL_RAM] & ram_err_i)
                       | (sel_q[`SS_SEL_SIM] & sim_err_i)
                       | (sel_q[`SS_SEL_TMR] & tmr_err_i);
  assign host_rdata_o  = ({`SS_DATA_W{sel_q[`SS_SEL_RAM]}} & ram_rdata_i)
                       | ({`SS_DATA_W{sel_q[`SS_SEL_SIM]}} & sim_rdata_i)
                       | ({`SS_DATA_W{sel_q[`SS_SEL_TMR]}} & tmr_rdata_i);

  // Windows must not overlap
  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(sel));

  // Devices answer exactly one cycle after acceptance
  a_rsp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (host_req_i && host_gnt_o) |=> host_rvalid_o);

  // Only the device that owes the response may answer
  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!ram_rvalid_i || sel_q[`SS_SEL_RAM]) &&
    (!sim_rvalid_i || sel_q[`SS_SEL_SIM]) &&
    (!tmr_rvalid_i || sel_q[`SS_SEL_TMR]));

endmodule

/* hdl/ram_1p.sv */
`timescale 1ns/1ns

module ram_1p #(
  parameter int Depth = 1024
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     req_i,
  input  logic                     we_i,
  input  simple_system_pkg::be_t   be_i,
  input  simple_system_pkg::addr_t addr_i,
  input  simple_system_pkg::data_t wdata_i,
  output logic                     rvalid_o,
  output simple_system_pkg::data_t rdata_o
);

  import simple_system_pkg::*;

  localparam int IdxW = $clog2(Depth);

  data_t           mem [Depth];
  logic [IdxW-1:0] word_idx;

  // Byte address to word index
  assign word_idx = addr_i[IdxW+1:2];

  // Read returns the word as it was before any write in the same cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < $bits(be_t); i++) begin
          if (be_i[i]) begin
            mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* hdl/sim_ctrl.sv */
`timescale 1ns/1ns
`include "simple_system_cfg.svh"

module sim_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     req_i,
  input  logic                     we_i,
  input  simple_system_pkg::be_t   be_i,
  input  simple_system_pkg::addr_t addr_i,
  input  simple_system_pkg::data_t wdata_i,
  output logic                     rvalid_o,
  output simple_system_pkg::data_t rdata_o,

  output logic                     char_valid_o,
  output logic [7:0]               char_o,
  output logic                     halt_o
);

  import simple_system_pkg::*;

  localparam addr_t CharOffset = 32'h0;
  localparam addr_t HaltOffset = 32'h8;

  addr_t offset;
  logic  char_wr;
  logic  halt_wr;

  // Offset inside the 1 kB window
  assign offset = addr_i & ~`SS_SIMCTRL_MASK;

  assign char_wr = req_i & we_i & (offset == CharOffset) & be_i[0];
  assign halt_wr = req_i & we_i & (offset == HaltOffset) & (be_i != '0);

  // Nothing readable here
  assign rdata_o = '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o     <= 1'b0;
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
    end else begin
      rvalid_o     <= req_i;
      char_valid_o <= char_wr;
      // Sticky until reset
      if (halt_wr) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_o <= wdata_i[7:0];
    end
  end

  // A character only appears alongside the response to a write
  a_char_after_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    char_valid_o |-> (rvalid_o && $past(req_i && we_i)));

endmodule

/* hdl/timer.sv */
`timescale 1ns/1ns
`include "simple_system_cfg.svh"

module timer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     req_i,
  input  logic                     we_i,
  input  simple_system_pkg::be_t   be_i,
  input  simple_system_pkg::addr_t addr_i,
  input  simple_system_pkg::data_t wdata_i,
  output logic                     rvalid_o,
  output simple_system_pkg::data_t rdata_o,
  output logic                     err_o,

  output logic                     irq_o
);

  import simple_system_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  addr_t       offset;
  logic        valid_off;
  logic [1:0]  reg_idx;
  logic        wr;
  data_t       rd_word;

  // Keep old bytes where the lane is disabled
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
    data_t res;
    res = old_w;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign offset    = addr_i & ~`SS_TIMER_MASK;
  // Only aligned words 0x0, 0x4, 0x8 and 0xC exist
  assign valid_off = (offset[`SS_DATA_W-1:4] == '0) && (offset[1:0] == 2'b00);
  assign reg_idx   = offset[3:2];
  assign wr        = req_i & we_i & valid_off;

  always_comb begin
    case (reg_idx)
      2'd0:    rd_word = mtime_q[31:0];
      2'd1:    rd_word = mtime_q[63:32];
      2'd2:    rd_word = mtimecmp_q[31:0];
      default: rd_word = mtimecmp_q[63:32];
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_o      <= 1'b0;
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      // A write to mtime replaces the increment
      if (wr && reg_idx == 2'd0) begin
        mtime_q <= {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, be_i)};
      end else if (wr && reg_idx == 2'd1) begin
        mtime_q <= {merge_bytes(mtime_q[63:32], wdata_i, be_i), mtime_q[31:0]};
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && reg_idx == 2'd2) begin
        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], wdata_i, be_i);
      end
      if (wr && reg_idx == 2'd3) begin
        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wdata_i, be_i);
      end
      irq_o    <= mtime_q >= mtimecmp_q;
      rvalid_o <= req_i;
      err_o    <= req_i & ~valid_off;
    end
  end

  // Read data, zero on writes and bad offsets
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (!we_i && valid_off) ? rd_word : '0;
    end
  end

endmodule

/* hdl/simple_system.sv */
`timescale 1ns/1ns
`include "simple_system_cfg.svh"

module simple_system (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     host_req_i,
  input  simple_system_pkg::addr_t host_addr_i,
  input  logic                     host_we_i,
  input  simple_system_pkg::be_t   host_be_i,
  input  simple_system_pkg::data_t host_wdata_i,
  output logic                     host_gnt_o,
  output logic                     host_rvalid_o,
  output simple_system_pkg::data_t host_rdata_o,
  output logic                     host_err_o,

  output logic                     char_valid_o,
  output logic [7:0]               char_o,
  output logic                     halt_o,
  output logic                     timer_irq_o
);

  import simple_system_pkg::*;

  logic  ram_req, ram_we, ram_rvalid;
  addr_t ram_addr;
  be_t   ram_be;
  data_t ram_wdata, ram_rdata;

  logic  sim_req, sim_we, sim_rvalid;
  addr_t sim_addr;
  be_t   sim_be;
  data_t sim_wdata, sim_rdata;

  logic  tmr_req, tmr_we, tmr_rvalid, tmr_err;
  addr_t tmr_addr;
  be_t   tmr_be;
  data_t tmr_wdata, tmr_rdata;

  // RAM and sim_ctrl never report errors
  bus u_bus (
    .clk_i, .arst_n_i,
    .host_req_i, .host_addr_i, .host_we_i, .host_be_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o, .host_err_o,
    .ram_req_o (ram_req), .ram_addr_o (ram_addr), .ram_we_o (ram_we),
    .ram_be_o (ram_be), .ram_wdata_o (ram_wdata),
    .ram_rvalid_i (ram_rvalid), .ram_rdata_i (ram_rdata), .ram_err_i (1'b0),
    .sim_req_o (sim_req), .sim_addr_o (sim_addr), .sim_we_o (sim_we),
    .sim_be_o (sim_be), .sim_wdata_o (sim_wdata),
    .sim_rvalid_i (sim_rvalid), .sim_rdata_i (sim_rdata), .sim_err_i (1'b0),
    .tmr_req_o (tmr_req), .tmr_addr_o (tmr_addr), .tmr_we_o (tmr_we),
    .tmr_be_o (tmr_be), .tmr_wdata_o (tmr_wdata),
    .tmr_rvalid_i (tmr_rvalid), .tmr_rdata_i (tmr_rdata), .tmr_err_i (tmr_err)
  );

  ram_1p #(
    .Depth (`SS_RAM_WORDS)
  ) u_ram (
    .clk_i, .arst_n_i,
    .req_i (ram_req), .we_i (ram_we), .be_i (ram_be),
    .addr_i (ram_addr), .wdata_i (ram_wdata),
    .rvalid_o (ram_rvalid), .rdata_o (ram_rdata)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i, .arst_n_i,
    .req_i (sim_req), .we_i (sim_we), .be_i (sim_be),
    .addr_i (sim_addr), .wdata_i (sim_wdata),
    .rvalid_o (sim_rvalid), .rdata_o (sim_rdata),
    .char_valid_o, .char_o, .halt_o
  );

  timer u_timer (
    .clk_i, .arst_n_i,
    .req_i (tmr_req), .we_i (tmr_we), .be_i (tmr_be),
    .addr_i (tmr_addr), .wdata_i (tmr_wdata),
    .rvalid_o (tmr_rvalid), .rdata_o (tmr_rdata), .err_o (tmr_err),
    .irq_o (timer_irq_o)
  );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 10 rising edges, released away from the edge
  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* verif/tb_simple_system.sv */
`timescale 1ns/1ns
`include "simple_system_cfg.svh"

module tb_simple_system;

  import simple_system_pkg::*;

  localparam int NumRamOps   = 300;
  localparam int NumUnmapped = 20;
  localparam int NumChars    = 16;
  localparam int NumHaltOps  = 30;
  // One cycle per transaction, plus about 100 for the timer waits
  localparam int TimeoutCycles = 8 * (NumRamOps + NumUnmapped + NumChars + NumHaltOps + 100);

  logic       clk_i;
  logic       arst_n_i;
  logic       host_req_i;
  addr_t      host_addr_i;
  logic       host_we_i;
  be_t        host_be_i;
  data_t      host_wdata_i;
  logic       host_gnt_o;
  logic       host_rvalid_o;
  data_t      host_rdata_o;
  logic       host_err_o;
  logic       char_valid_o;
  logic [7:0] char_o;
  logic       halt_o;
  logic       timer_irq_o;

  // Reference model, with a known flag per RAM byte
  data_t       ram_model [`SS_RAM_WORDS];
  logic [3:0]  ram_known [`SS_RAM_WORDS];
  logic        halt_model;
  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          issue_idx;
  int          errors;
  int          errors_at_start;
  int          tests_passed;
  int          tests_failed;
  data_t       last_rdata;

  // Expectation for the request driven now (st_) and the one being answered (fl_)
  logic       st_valid, st_err, st_char, st_halt;
  data_t      st_data, st_mask;
  logic [7:0] st_byte;
  logic       fl_valid, fl_err, fl_char, fl_halt;
  data_t      fl_data, fl_mask;
  logic [7:0] fl_byte;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  simple_system i_simple_system (
    .clk_i, .arst_n_i,
    .host_req_i, .host_addr_i, .host_we_i, .host_be_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o, .host_err_o,
    .char_valid_o, .char_o, .halt_o, .timer_irq_o
  );

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("TIMEOUT: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    // Upper half has the longer period, move it down
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  function automatic logic in_window(input addr_t a);
    return ((a & `SS_RAM_MASK) == `SS_RAM_BASE) ||
           ((a & `SS_SIMCTRL_MASK) == `SS_SIMCTRL_BASE) ||
           ((a & `SS_TIMER_MASK) == `SS_TIMER_BASE);
  endfunction

  task automatic mismatch(input string msg);
    errors = errors + 1;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed = tests_passed + 1;
      $display("PASS %s", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("FAIL %s with %0d mismatches", name, errors - errors_at_start);
    end
  endtask

  // Response to the request accepted at the last rising edge
  task automatic check_response();
    if (host_rvalid_o !== fl_valid) begin
      mismatch($sformatf("host_rvalid_o %b, expected %b", host_rvalid_o, fl_valid));
    end
    if (fl_valid) begin
      last_rdata = host_rdata_o;
      if (host_err_o !== fl_err) begin
        mismatch($sformatf("host_err_o %b, expected %b", host_err_o, fl_err));
      end
      if (((host_rdata_o ^ fl_data) & fl_mask) !== '0) begin
        mismatch($sformatf("host_rdata_o %h, expected %h under mask %h",
                           host_rdata_o, fl_data, fl_mask));
      end
    end
    if (char_valid_o !== fl_char) begin
      mismatch($sformatf("char_valid_o %b, expected %b", char_valid_o, fl_char));
    end
    if (fl_char && char_o !== fl_byte) begin
      mismatch($sformatf("char_o %h, expected %h", char_o, fl_byte));
    end
    if (fl_halt) begin
      halt_model = 1'b1;
    end
    if (halt_o !== halt_model) begin
      mismatch($sformatf("halt_o %b, expected %b", halt_o, halt_model));
    end
  endtask

  // Drive one request (or an idle cycle), then check the previous one
  task automatic bus_cycle(input logic req, input addr_t addr, input logic we,
                           input be_t be, input data_t wdata);
    @(posedge clk_i);
    issue_idx = issue_idx + 1;
    host_req_i   <= req;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    @(negedge clk_i);
    // No back-pressure, the grant follows the request
    if (host_gnt_o !== req) begin
      mismatch($sformatf("host_gnt_o %b, expected %b", host_gnt_o, req));
    end
    check_response();
    fl_valid = st_valid;
    fl_err   = st_err;
    fl_data  = st_data;
    fl_mask  = st_mask;
    fl_char  = st_char;
    fl_byte  = st_byte;
    fl_halt  = st_halt;
    st_valid = 1'b0;
    st_err   = 1'b0;
    st_mask  = '0;
    st_char  = 1'b0;
    st_halt  = 1'b0;
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic ram_access(input logic we, input logic [9:0] idx, input be_t be,
                            input data_t wdata);
    st_valid = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (we && be[i]) begin
        ram_model[idx][8*i +: 8] = wdata[8*i +: 8];
        ram_known[idx][i] = 1'b1;
      end
      st_mask[8*i +: 8] = {8{!we && ram_known[idx][i]}};
    end
    st_data = ram_model[idx];
    bus_cycle(1'b1, `SS_RAM_BASE + {20'd0, idx, 2'b00}, we, be, wdata);
  endtask

  task automatic random_ram_op();
    logic [31:0] r;
    r = next_rand();
    // Half the traffic stays in 16 words so reads meet earlier writes
    ram_access(r[31], r[30] ? {6'd0, r[3:0]} : r[9:0], r[19:16], next_rand());
  endtask

  task automatic sim_write(input addr_t offset, input be_t be, input data_t wdata);
    st_valid = 1'b1;
    st_char  = (offset == 32'h0) && be[0];
    st_byte  = wdata[7:0];
    st_halt  = (offset == 32'h8);
    bus_cycle(1'b1, `SS_SIMCTRL_BASE + offset, 1'b1, be, wdata);
  endtask

  task automatic timer_access(input logic we, input addr_t offset, input data_t wdata);
    st_valid = 1'b1;
    st_err   = (offset > 32'hC) || (offset[1:0] != 2'b00);
    bus_cycle(1'b1, `SS_TIMER_BASE + offset, we, 4'hF, wdata);
  endtask

  task automatic unmapped_access(input addr_t addr, input logic we);
    st_valid = 1'b1;
    st_err   = 1'b1;
    st_data  = '0;
    st_mask  = '1;
    bus_cycle(1'b1, addr, we, 4'hF, next_rand());
  endtask

  initial begin
    logic [31:0] r;
    addr_t       addr;
    int          c_first;
    int          c_second;
    data_t       t_first;
    int          c_read;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    rng_state    = 32'h5d8b;
    issue_idx    = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    halt_model   = 1'b0;
    last_rdata   = '0;
    fl_valid = 1'b0;
    fl_char  = 1'b0;
    fl_halt  = 1'b0;
    st_valid = 1'b0;
    st_err   = 1'b0;
    st_mask  = '0;
    st_char  = 1'b0;
    st_halt  = 1'b0;
    for (int i = 0; i < `SS_RAM_WORDS; i++) begin
      ram_known[i] = '0;
    end
    wait (arst_n_i === 1'b1);
    @(negedge clk_i);

    start_test();
    if ({host_rvalid_o, host_err_o, char_valid_o, halt_o, timer_irq_o} !== 5'b0) begin
      mismatch($sformatf("rvalid/err/char_valid/halt/irq = %b after reset, expected 00000",
                         {host_rvalid_o, host_err_o, char_valid_o, halt_o, timer_irq_o}));
    end
    end_test("reset values");

    start_test();
    repeat (NumRamOps) random_ram_op();
    idle_cycle();
    end_test("RAM random traffic");

    start_test();
    repeat (NumUnmapped) begin
      r = next_rand();
      // Just above the RAM window, where a bad decode would alias the busy words
      addr = r[31] ? `SS_RAM_BASE + 32'h1000 + {26'd0, r[3:0], 2'b00} : next_rand();
      while (in_window(addr)) begin
        addr = next_rand();
      end
      unmapped_access(addr, r[30]);
    end
    repeat (16) begin
      r = next_rand();
      ram_access(1'b0, {6'd0, r[3:0]}, 4'hF, '0);
    end
    idle_cycle();
    end_test("unmapped addresses");

    start_test();
    repeat (NumChars) begin
      r = next_rand();
      sim_write(32'h0, r[19:16] | 4'h1, r);
    end
    idle_cycle();
    end_test("character output");

    start_test();
    // mtime advances by one per cycle
    timer_access(1'b0, 32'h0, '0);
    c_first = issue_idx;
    r = next_rand();
    repeat (3 + r[3:0]) idle_cycle();
    t_first = last_rdata;
    timer_access(1'b0, 32'h0, '0);
    c_second = issue_idx;
    idle_cycle();
    if (last_rdata - t_first !== data_t'(c_second - c_first)) begin
      mismatch($sformatf("mtime moved by %0d over %0d cycles",
                         last_rdata - t_first, c_second - c_first));
    end
    // Compare value 50 ahead of mtime at the cycle of the low-word write
    timer_access(1'b0, 32'h0, '0);
    c_read = issue_idx;
    timer_access(1'b1, 32'hC, '0);
    timer_access(1'b1, 32'h8, last_rdata + data_t'(issue_idx + 1 - c_read) + 32'd50);
    idle_cycle();
    if (timer_irq_o !== 1'b0) begin
      mismatch("timer_irq_o high right after the mtimecmp write");
    end
    repeat (40) idle_cycle();
    if (timer_irq_o !== 1'b0) begin
      mismatch("timer_irq_o high 40 cycles after the mtimecmp write");
    end
    repeat (20) idle_cycle();
    if (timer_irq_o !== 1'b1) begin
      mismatch("timer_irq_o still low 60 cycles after the mtimecmp write");
    end
    timer_access(1'b0, 32'h10, '0);
    idle_cycle();
    end_test("timer");

    start_test();
    sim_write(32'h8, 4'hF, next_rand());
    repeat (NumHaltOps) random_ram_op();
    idle_cycle();
    end_test("halt");

    $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* simple_system.f */
+incdir+include
hdl/simple_system_pkg.sv
hdl/bus.sv
hdl/ram_1p.sv
hdl/sim_ctrl.sv
hdl/timer.sv
hdl/simple_system.sv
verif/tb_clk_gen.sv
verif/tb_simple_system.sv

/* Makefile */
TOP := tb_simple_system

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f simple_system.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Everything OK'

lint:
	verilator --lint-only --timing -f simple_system.f --top-module simple_system

clean:
	rm -rf obj_dir
